// ==== all.f ====
common/muldiv_pkg.sv
common/muldiv_result_if.sv
source/muldiv_issue.sv
multiplier/mul_pipe.sv
divider/div_iter.sv
source/hilo_writeback.sv
source/muldiv_unit.sv
sim/muldiv_assert.sv
sim/muldiv_tb.sv

// ==== common/muldiv_pkg.sv ====
package muldiv_pkg;

	typedef logic [31:0] word_t;    // operand or register word
	typedef logic [63:0] dword_t;   // product or {hi, lo}

	// 0..8 match the core's ALU2Op field and the moves follow
	typedef enum logic [3:0] {
		OP_MULT  = 4'd0,
		OP_MULTU = 4'd1,
		OP_DIV   = 4'd2,
		OP_DIVU  = 4'd3,
		OP_MADDU = 4'd4,
		OP_MADD  = 4'd5,
		OP_MSUB  = 4'd6,
		OP_MSUBU = 4'd7,
		OP_MUL   = 4'd8,
		OP_MTHI  = 4'd9,
		OP_MTLO  = 4'd10
	} muldiv_op_e;

	localparam int MUL_STAGES = 4;                   // register stages in mul_pipe
	localparam int DIV_CYCLES = 32;                  // one quotient bit per cycle
	localparam int DIV_CNT_W  = $clog2(DIV_CYCLES);
	localparam int INFLIGHT_W = 3;                   // holds MUL_STAGES+1

	function automatic logic is_div(muldiv_op_e op);
		return (op == OP_DIV) || (op == OP_DIVU);
	endfunction

	function automatic logic is_move(muldiv_op_e op);
		return (op == OP_MTHI) || (op == OP_MTLO);
	endfunction

	// two's complement operand handling
	function automatic logic is_signed_mul(muldiv_op_e op);
		return (op == OP_MULT) || (op == OP_MADD) || (op == OP_MSUB) || (op == OP_MUL);
	endfunction

endpackage

// ==== common/muldiv_result_if.sv ====
`timescale 1ns/10ps

interface muldiv_result_if;
	import muldiv_pkg::*;

	logic       valid;     // single-cycle pulse without ready
	muldiv_op_e op;
	word_t      hi_word;   // product high word or remainder
	word_t      lo_word;   // product low word, quotient or move data

	modport src (
		output valid,
		output op,
		output hi_word,
		output lo_word
	);

	modport dst (
		input valid,
		input op,
		input hi_word,
		input lo_word
	);

endinterface

// ==== divider/div_iter.sv ====
`timescale 1ns/10ps

module div_iter (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   req_valid,
	input  muldiv_pkg::muldiv_op_e req_op,
	input  muldiv_pkg::word_t      req_a,
	input  muldiv_pkg::word_t      req_b,
	muldiv_result_if.src           res
);
	import muldiv_pkg::*;

	typedef enum logic [1:0] {
		D_IDLE,
		D_RUN,
		D_DONE
	} div_state_e;

	div_state_e           state;
	logic [DIV_CNT_W-1:0] cnt;
	logic                 signed_op;
	logic                 neg_a;
	logic                 neg_b;
	word_t                mag_a;
	word_t                mag_b;
	word_t                quo;     // dividend bits shift out as quotient bits shift in
	word_t                rem;
	word_t                dvs;
	logic                 neg_q;
	logic                 neg_r;
	muldiv_op_e           op_q;
	logic [32:0]          shifted;
	logic [32:0]          diff;
	logic                 ge;
	word_t                rem_next;

	assign signed_op = (req_op == OP_DIV);
	assign neg_a     = signed_op && req_a[31];
	assign neg_b     = signed_op && req_b[31];
	assign mag_a     = neg_a ? -req_a : req_a;   // -2^31 maps to 2^31
	assign mag_b     = neg_b ? -req_b : req_b;

	// one restoring step
	assign shifted  = {rem, quo[31]};
	assign diff     = shifted - {1'b0, dvs};
	assign ge       = (shifted >= {1'b0, dvs});
	assign rem_next = ge ? diff[31:0] : shifted[31:0];

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= D_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				D_IDLE: begin
					if (req_valid) begin
						state <= D_RUN;
						cnt   <= '0;
					end
				end
				D_RUN: begin
					cnt <= cnt + DIV_CNT_W'(1);
					if (cnt == DIV_CNT_W'(DIV_CYCLES - 1)) begin
						state <= D_DONE;
					end
				end
				D_DONE: state <= D_IDLE;   // result shown for one cycle
				default: state <= D_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == D_IDLE) && req_valid) begin
			quo   <= mag_a;
			rem   <= '0;
			dvs   <= mag_b;
			neg_q <= neg_a ^ neg_b;
			neg_r <= neg_a;   // remainder follows the dividend
			op_q  <= req_op;
		end else if (state == D_RUN) begin
			quo <= {quo[30:0], ge};
			rem <= rem_next;
		end
	end

	// sign fixup on the way out
	assign res.valid   = (state == D_DONE);
	assign res.op      = op_q;
	assign res.hi_word = neg_r ? -rem : rem;
	assign res.lo_word = neg_q ? -quo : quo;

endmodule

// ==== multiplier/mul_pipe.sv ====
`timescale 1ns/10ps

module mul_pipe (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   req_valid,
	input  muldiv_pkg::muldiv_op_e req_op,
	input  muldiv_pkg::word_t      req_a,
	input  muldiv_pkg::word_t      req_b,
	muldiv_result_if.src           res
);
	import muldiv_pkg::*;

	logic signed [32:0]    ext_a;
	logic signed [32:0]    ext_b;
	logic signed [32:0]    a_q;
	logic signed [32:0]    b_q;
	logic signed [65:0]    prod_full;
	logic [MUL_STAGES-1:0] v_q;
	muldiv_op_e            op_q [MUL_STAGES];
	dword_t                p_q [MUL_STAGES-1];

	// 33-bit operands let one signed multiplier serve both flavours
	always_comb begin
		if (is_move(req_op)) begin
			ext_a = {1'b0, req_a};   // move data times one
			ext_b = 33'sd1;
		end else if (is_signed_mul(req_op)) begin
			ext_a = {req_a[31], req_a};
			ext_b = {req_b[31], req_b};
		end else begin
			ext_a = {1'b0, req_a};
			ext_b = {1'b0, req_b};
		end
	end

	assign prod_full = a_q * b_q;   // low 64 bits are exact for either sign

	always_ff @(posedge clk) begin
		if (!rst) begin
			v_q <= '0;
		end else begin
			v_q <= {v_q[MUL_STAGES-2:0], req_valid};
		end
	end

	// first stage holds operands and the rest carry the product
	always_ff @(posedge clk) begin
		a_q     <= ext_a;
		b_q     <= ext_b;
		op_q[0] <= req_op;
		p_q[0]  <= prod_full[63:0];
		for (int i = 1; i < MUL_STAGES; i++) begin
			op_q[i] <= op_q[i-1];
		end
		for (int j = 1; j < MUL_STAGES - 1; j++) begin
			p_q[j] <= p_q[j-1];   // retiming room for the multiplier
		end
	end

	assign res.valid   = v_q[MUL_STAGES-1];
	assign res.op      = op_q[MUL_STAGES-1];
	assign res.hi_word = p_q[MUL_STAGES-2][63:32];
	assign res.lo_word = p_q[MUL_STAGES-2][31:0];

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run with Verilator, pass only when the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module muldiv_tb -f all.f || exit 1
out=$(./obj_dir/Vmuldiv_tb +verilator+error+limit+1000 2>&1)
echo "$out"
echo "$out" | grep -qx "Finished with no errors" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== sim/muldiv_assert.sv ====
`timescale 1ns/10ps

module muldiv_assert (
	input logic                   clk,
	input logic                   rst,
	input logic                   op_valid,
	input logic                   op_ready,
	input muldiv_pkg::muldiv_op_e op_code,
	input muldiv_pkg::word_t      src_a,
	input muldiv_pkg::word_t      src_b,
	input muldiv_pkg::word_t      hi,
	input muldiv_pkg::word_t      lo,
	input logic                   busy,
	input logic                   mul_valid,
	input muldiv_pkg::word_t      mul_result
);
	import muldiv_pkg::*;

	localparam int LAT = MUL_STAGES + 1;   // accept edge to hi/lo update

	int           err_count = 0;
	dword_t       model;        // hi/lo after every accepted op in program order
	dword_t       model_next;
	logic         accept;
	logic         div_op;
	logic [LAT:0] due;          // multiplier-side results on their way
	logic [LAT:0] due_mul;      // the MUL subset
	dword_t       exp_q [LAT+1];
	logic         div_pend;
	int           div_age;
	dword_t       div_exp;
	logic         busy_q;
	logic         rst_q;

	function automatic dword_t signed_product(word_t a, word_t b);
		longint sa;
		longint sb;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		return dword_t'(sa * sb);
	endfunction

	function automatic dword_t unsigned_product(word_t a, word_t b);
		return {32'd0, a} * {32'd0, b};
	endfunction

	// 64-bit math keeps -2^31 / -1 well defined
	function automatic dword_t signed_divide(word_t a, word_t b);
		longint sa;
		longint sb;
		longint q;
		longint r;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		q  = sa / sb;   // truncates toward zero
		r  = sa % sb;   // sign of the dividend
		return {r[31:0], q[31:0]};
	endfunction

	function automatic dword_t unsigned_divide(word_t a, word_t b);
		return {a % b, a / b};
	endfunction

	assign accept = op_valid && op_ready;
	assign div_op = (op_code == OP_DIV) || (op_code == OP_DIVU);

	always_comb begin
		case (op_code)
			OP_MULT,
			OP_MUL:   model_next = signed_product(src_a, src_b);
			OP_MULTU: model_next = unsigned_product(src_a, src_b);
			OP_MADD:  model_next = model + signed_product(src_a, src_b);
			OP_MADDU: model_next = model + unsigned_product(src_a, src_b);
			OP_MSUB:  model_next = model - signed_product(src_a, src_b);
			OP_MSUBU: model_next = model - unsigned_product(src_a, src_b);
			OP_DIV:   model_next = signed_divide(src_a, src_b);
			OP_DIVU:  model_next = unsigned_divide(src_a, src_b);
			OP_MTHI:  model_next = {src_a, model[31:0]};
			OP_MTLO:  model_next = {model[63:32], src_a};
			default:  model_next = model;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			model    <= '0;
			due      <= '0;
			due_mul  <= '0;
			div_pend <= 1'b0;
			div_age  <= 0;
		end else begin
			due     <= {due[LAT-1:0], accept && !div_op};
			due_mul <= {due_mul[LAT-1:0], accept && (op_code == OP_MUL)};
			if (accept) begin
				model <= model_next;
			end
			if (accept && div_op) begin
				div_pend <= 1'b1;
				div_age  <= 0;
				div_exp  <= model_next;
			end else if (div_pend && busy_q && !busy) begin
				div_pend <= 1'b0;
			end else if (div_pend) begin
				div_age <= div_age + 1;
			end
		end
	end

	always_ff @(posedge clk) begin
		rst_q    <= rst;
		busy_q   <= busy;
		exp_q[0] <= model_next;
		for (int i = 1; i <= LAT; i++) begin
			exp_q[i] <= exp_q[i-1];
		end
	end

	a_reset_flags: assert property (@(posedge clk)
			(rst && !rst_q) |-> (op_ready && !busy && !mul_valid))
		else begin
			err_count = err_count + 1;
			$error("handshake flags wrong after reset");
		end
	a_reset_hilo: assert property (@(posedge clk) (rst && !rst_q) |-> ({hi, lo} == '0))
		else begin
			err_count = err_count + 1;
			$error("MISMATCH {hi,lo}: got %h expected 0", {hi, lo});
		end
	a_mul_hilo: assert property (@(posedge clk) disable iff (!rst)
			due[LAT] |-> ({hi, lo} == exp_q[LAT]))
		else begin
			err_count = err_count + 1;
			$error("MISMATCH {hi,lo}: got %h expected %h", {hi, lo}, exp_q[LAT]);
		end
	a_mul_valid: assert property (@(posedge clk) disable iff (!rst) mul_valid == due_mul[LAT])
		else begin
			err_count = err_count + 1;
			$error("MISMATCH mul_valid: got %h expected %h", mul_valid, due_mul[LAT]);
		end
	a_mul_result: assert property (@(posedge clk) disable iff (!rst)
			due_mul[LAT] |-> (mul_result == exp_q[LAT][31:0]))
		else begin
			err_count = err_count + 1;
			$error("MISMATCH mul_result: got %h expected %h", mul_result, exp_q[LAT][31:0]);
		end
	a_div_value: assert property (@(posedge clk) disable iff (!rst)
			(div_pend && busy_q && !busy) |-> ({hi, lo} == div_exp))
		else begin
			err_count = err_count + 1;
			$error("MISMATCH {hi,lo}: got %h expected %h", {hi, lo}, div_exp);
		end
	a_div_latency: assert property (@(posedge clk) disable iff (!rst)
			(div_pend && busy_q && !busy) |-> (div_age == DIV_CYCLES + 2))
		else begin
			err_count = err_count + 1;
			$error("divide took %0d cycles", div_age);
		end
	a_div_blocks: assert property (@(posedge clk) disable iff (!rst)
			(div_pend && busy) |-> !op_ready)
		else begin
			err_count = err_count + 1;
			$error("op_ready high while a divide runs");
		end
	a_div_order: assert property (@(posedge clk) disable iff (!rst)
			(accept && div_op) |-> (due[LAT-1:0] == '0))
		else begin
			err_count = err_count + 1;
			$error("divide accepted before multiplies drained");
		end

endmodule

bind muldiv_unit muldiv_assert chk (
	.clk        (clk),
	.rst        (rst),
	.op_valid   (op_valid),
	.op_ready   (op_ready),
	.op_code    (op_code),
	.src_a      (src_a),
	.src_b      (src_b),
	.hi         (hi),
	.lo         (lo),
	.busy       (busy),
	.mul_valid  (mul_valid),
	.mul_result (mul_result)
);

// ==== sim/muldiv_tb.sv ====
`timescale 1ns/10ps

module muldiv_tb;
	import muldiv_pkg::*;

	localparam int          CLK_PERIOD = 8;
	localparam logic [31:0] SEED       = 32'hd0f3_8002;
	localparam int          N_MULT     = 32;
	localparam int          N_CHAINS   = 4;
	localparam int          CHAIN_LEN  = 10;
	localparam int          N_DIV      = 20;
	localparam int          N_STALL    = 4;
	localparam int          N_MUL3     = 24;
	// chains open with MTHI and MTLO, two fixed divides, six ops per stall round
	localparam int TOTAL_OPS = N_MULT + N_CHAINS * (CHAIN_LEN + 2) + N_DIV + 2 +
		N_STALL * 6 + N_MUL3;
	localparam int WATCHDOG_NS = TOTAL_OPS * (DIV_CYCLES + 8) * CLK_PERIOD;

	logic       clk = 1'b0;
	logic       rst;
	logic       op_valid;
	logic       op_ready;
	muldiv_op_e op_code;
	word_t      src_a;
	word_t      src_b;
	word_t      hi;
	word_t      lo;
	logic       busy;
	logic       mul_valid;
	word_t      mul_result;
	int         tests_run = 0;
	int         errs_before = 0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	muldiv_unit dut (
		.clk        (clk),
		.rst        (rst),
		.op_valid   (op_valid),
		.op_ready   (op_ready),
		.op_code    (op_code),
		.src_a      (src_a),
		.src_b      (src_b),
		.hi         (hi),
		.lo         (lo),
		.busy       (busy),
		.mul_valid  (mul_valid),
		.mul_result (mul_result)
	);

	// full-width words or small sign-extended ones so quotients are not all zero
	function automatic word_t rand_word();
		word_t w;
		w = $urandom;
		if ($urandom_range(0, 1) == 1) begin
			w = {{24{w[31]}}, w[7:0]};
		end
		return w;
	endfunction

	function automatic word_t nonzero_word();
		word_t w;
		w = rand_word();
		return (w == '0) ? 32'd1 : w;
	endfunction

	// called on a rising edge and returns on the edge that accepts the op
	task automatic send(muldiv_op_e op, word_t a, word_t b);
		op_valid <= 1'b1;
		op_code  <= op;
		src_a    <= a;
		src_b    <= b;
		@(negedge clk);
		while (!op_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
	endtask

	task automatic drain();
		op_valid <= 1'b0;
		@(negedge clk);
		while (busy) begin
			@(negedge clk);
		end
		repeat (2) @(posedge clk);
	endtask

	task automatic report(string name);
		tests_run++;
		$display("test %s finished, %0d assertion failures", name,
			dut.chk.err_count - errs_before);
		errs_before = dut.chk.err_count;
	endtask

	task automatic mult_back_to_back();
		for (int i = 0; i < N_MULT; i++) begin
			send(($urandom & 1) ? OP_MULTU : OP_MULT, rand_word(), rand_word());
		end
		drain();
		report("mult");
	endtask

	task automatic mac_chains();
		muldiv_op_e op;
		for (int c = 0; c < N_CHAINS; c++) begin
			send(OP_MTHI, rand_word(), '0);
			send(OP_MTLO, rand_word(), '0);
			for (int i = 0; i < CHAIN_LEN; i++) begin
				case ($urandom_range(0, 3))
					0: op = OP_MADD;
					1: op = OP_MADDU;
					2: op = OP_MSUB;
					default: op = OP_MSUBU;
				endcase
				send(op, rand_word(), rand_word());
			end
		end
		drain();
		report("mac");
	endtask

	task automatic divides();
		send(OP_DIV, 32'h8000_0000, 32'hffff_ffff);   // signed overflow case
		send(OP_DIVU, 32'h8000_0000, 32'hffff_ffff);
		for (int i = 0; i < N_DIV; i++) begin
			send(($urandom & 1) ? OP_DIVU : OP_DIV, rand_word(), nonzero_word());
		end
		drain();
		report("divide");
	endtask

	task automatic div_stall();
		for (int r = 0; r < N_STALL; r++) begin
			for (int i = 0; i < 4; i++) begin
				send(OP_MADD, rand_word(), rand_word());
			end
			send(OP_DIV, rand_word(), nonzero_word());   // waits for the multiplier
			send(OP_MULT, rand_word(), rand_word());     // waits for the divider
		end
		drain();
		report("div_stall");
	endtask

	task automatic mul_three_operand();
		for (int i = 0; i < N_MUL3; i++) begin
			send(($urandom & 1) ? OP_MUL : OP_MADD, rand_word(), rand_word());
		end
		drain();
		report("mul");
	endtask

	initial begin
		int seed_ret;
		seed_ret = $urandom(SEED);
		rst      = 1'b0;
		op_valid = 1'b0;
		op_code  = OP_MULT;
		src_a    = '0;
		src_b    = '0;
		repeat (16) @(posedge clk);
		rst <= 1'b1;
		repeat (2) @(posedge clk);
		report("reset");
		mult_back_to_back();
		mac_chains();
		divides();
		div_stall();
		mul_three_operand();
		$display("tests run %0d, assertion failures %0d", tests_run, dut.chk.err_count);
		if (dut.chk.err_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
		$display("Finished with errors");
		$finish;
	end

endmodule

// ==== source/hilo_writeback.sv ====
`timescale 1ns/10ps

module hilo_writeback (
	input  logic              clk,
	input  logic              rst,
	muldiv_result_if.dst      mul_res,
	muldiv_result_if.dst      div_res,
	output muldiv_pkg::word_t hi,
	output muldiv_pkg::word_t lo,
	output logic              mul_valid,
	output muldiv_pkg::word_t mul_result
);
	import muldiv_pkg::*;

	dword_t hilo;
	dword_t prod;
	dword_t hilo_next;
	logic   is_mul;

	assign prod   = {mul_res.hi_word, mul_res.lo_word};
	assign is_mul = mul_res.valid && (mul_res.op == OP_MUL);

	// issue keeps the two sources from landing in the same cycle
	always_comb begin
		hilo_next = hilo;
		if (mul_res.valid) begin
			case (mul_res.op)
				OP_MADD,
				OP_MADDU: hilo_next = hilo + prod;
				OP_MSUB,
				OP_MSUBU: hilo_next = hilo - prod;
				OP_MTHI:  hilo_next = {mul_res.lo_word, hilo[31:0]};
				OP_MTLO:  hilo_next = {hilo[63:32], mul_res.lo_word};
				default:  hilo_next = prod;   // MULT, MULTU, MUL
			endcase
		end else if (div_res.valid) begin
			hilo_next = {div_res.hi_word, div_res.lo_word};   // {rem, quo}
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			hilo      <= '0;
			mul_valid <= 1'b0;
		end else begin
			hilo      <= hilo_next;
			mul_valid <= is_mul;   // lines up with the hi/lo update
		end
	end

	always_ff @(posedge clk) begin
		if (is_mul) begin
			mul_result <= mul_res.lo_word;
		end
	end

	assign hi = hilo[63:32];
	assign lo = hilo[31:0];

endmodule

// ==== source/muldiv_issue.sv ====
`timescale 1ns/10ps

module muldiv_issue (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   op_valid,
	input  muldiv_pkg::muldiv_op_e op_code,
	input  muldiv_pkg::word_t      src_a,
	input  muldiv_pkg::word_t      src_b,
	input  logic                   mul_done,
	input  logic                   div_done,
	output logic                   op_ready,
	output logic                   busy,
	output logic                   mul_req_valid,
	output muldiv_pkg::muldiv_op_e mul_req_op,
	output logic                   div_req_valid,
	output muldiv_pkg::muldiv_op_e div_req_op,
	output muldiv_pkg::word_t      req_a,
	output muldiv_pkg::word_t      req_b
);
	import muldiv_pkg::*;

	logic [INFLIGHT_W-1:0] inflight;   // ops between accept and mul result
	logic                  div_busy;
	logic                  to_div;
	logic                  accept;
	logic                  mul_accept;
	muldiv_op_e            req_op;

	assign to_div     = is_div(op_code);
	// a divide waits for the multiplier to drain so results stay in order
	assign op_ready   = !div_busy && (!to_div || (inflight == '0));
	assign accept     = op_valid && op_ready;
	assign mul_accept = accept && !to_div;   // moves ride the multiplier too

	assign busy = div_busy || (inflight != '0);

	always_ff @(posedge clk) begin
		if (!rst) begin
			inflight <= '0;
		end else if (mul_accept && !mul_done) begin
			inflight <= inflight + INFLIGHT_W'(1);
		end else if (!mul_accept && mul_done) begin
			inflight <= inflight - INFLIGHT_W'(1);
		end
	end

	// accept and done never meet here since ready is low while a divide runs
	always_ff @(posedge clk) begin
		if (!rst) begin
			div_busy <= 1'b0;
		end else if (div_done) begin
			div_busy <= 1'b0;
		end else if (accept && to_div) begin
			div_busy <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			mul_req_valid <= 1'b0;
			div_req_valid <= 1'b0;
		end else begin
			mul_req_valid <= mul_accept;
			div_req_valid <= accept && to_div;
		end
	end

	// operands shared by both stages
	always_ff @(posedge clk) begin
		if (accept) begin
			req_op <= op_code;
			req_a  <= src_a;
			req_b  <= src_b;
		end
	end

	assign mul_req_op = req_op;
	assign div_req_op = req_op;

endmodule

// ==== source/muldiv_unit.sv ====
`timescale 1ns/10ps

module muldiv_unit (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   op_valid,
	output logic                   op_ready,
	input  muldiv_pkg::muldiv_op_e op_code,
	input  muldiv_pkg::word_t      src_a,
	input  muldiv_pkg::word_t      src_b,
	output muldiv_pkg::word_t      hi,
	output muldiv_pkg::word_t      lo,
	output logic                   busy,
	output logic                   mul_valid,
	output muldiv_pkg::word_t      mul_result
);
	import muldiv_pkg::*;

	logic       mul_req_valid;
	muldiv_op_e mul_req_op;
	logic       div_req_valid;
	muldiv_op_e div_req_op;
	word_t      req_a;
	word_t      req_b;

	muldiv_result_if mul_res ();
	muldiv_result_if div_res ();

	muldiv_issue u_issue (
		.clk           (clk),
		.rst           (rst),
		.op_valid      (op_valid),
		.op_code       (op_code),
		.src_a         (src_a),
		.src_b         (src_b),
		.mul_done      (mul_res.valid),
		.div_done      (div_res.valid),
		.op_ready      (op_ready),
		.busy          (busy),
		.mul_req_valid (mul_req_valid),
		.mul_req_op    (mul_req_op),
		.div_req_valid (div_req_valid),
		.div_req_op    (div_req_op),
		.req_a         (req_a),
		.req_b         (req_b)
	);

	mul_pipe u_mul (
		.clk       (clk),
		.rst       (rst),
		.req_valid (mul_req_valid),
		.req_op    (mul_req_op),
		.req_a     (req_a),
		.req_b     (req_b),
		.res       (mul_res.src)
	);

	div_iter u_div (
		.clk       (clk),
		.rst       (rst),
		.req_valid (div_req_valid),
		.req_op    (div_req_op),
		.req_a     (req_a),
		.req_b     (req_b),
		.res       (div_res.src)
	);

	hilo_writeback u_wb (
		.clk        (clk),
		.rst        (rst),
		.mul_res    (mul_res.dst),
		.div_res    (div_res.dst),
		.hi         (hi),
		.lo         (lo),
		.mul_valid  (mul_valid),
		.mul_result (mul_result)
	);

endmodule
